// ==== compile.f ====
hw/fixed_div_pkg.sv
hw/div_operand_if.sv
hw/div_result_if.sv
hw/operand_fifo.sv
hw/long_division_core.sv
hw/div_result_stage.sv
hw/fixed_divider_top.sv
sim/fixed_divider_chk.sv
sim/fixed_divider_scoreboard.sv
sim/fixed_divider_tb.sv

// ==== hw/div_operand_if.sv ====
/*
  Operand handshake between the queue and the division core
  - valid/ready strobes and one dividend/divisor pair
  - src modport for the queue, dst modport for the core
*/

`timescale 1ns/1ns

interface div_operand_if #(
  parameter int N_BITS = 16
);

  // Pair moves on an edge where valid and ready are both high
  logic                     valid;
  logic                     ready;
  logic signed [N_BITS-1:0] dividend;
  logic signed [N_BITS-1:0] divisor;

  // Queue side holds valid and data steady until accepted
  modport src (output valid, output dividend, output divisor, input ready);

  // Core side raises ready while it is idle
  modport dst (input valid, input dividend, input divisor, output ready);

endinterface

// ==== hw/div_result_if.sv ====
/*
  Raw result path from the division core to the result stage
  - one-cycle valid pulse, quotient, remainder and overflow flag
  - no ready, the result stage always takes the data
*/

`timescale 1ns/1ns

interface div_result_if #(
  parameter int N_BITS = 16
);

  // Data is only meaningful in the cycle where valid is high
  logic                     valid;
  logic signed [N_BITS-1:0] quotient;
  logic signed [N_BITS-1:0] remainder;
  logic                     overflow;

  modport src (output valid, output quotient, output remainder, output overflow);

  modport dst (input valid, input quotient, input remainder, input overflow);

endinterface

// ==== hw/div_result_stage.sv ====
/*
  Result stage after the division core
  - clamps overflowed quotients to the largest value of the right sign
  - output register with a one-cycle valid pulse
  - saturating count of overflowed results
*/

`timescale 1ns/1ns

module div_result_stage import fixed_div_pkg::*; #(
  parameter int N_BITS = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  div_result_if.dst  res,
  output logic       out_valid,
  output fix_t       out_quotient,
  output fix_t       out_remainder,
  output logic       out_saturated,
  output ovf_cnt_t   overflow_count
);

  // Largest positive quotient, 0111...1
  localparam logic signed [N_BITS-1:0] Q_MAX = {1'b0, {(N_BITS-1){1'b1}}};

  logic signed [N_BITS-1:0] sat_quo;

  // Core leaves the raw quotient negative on overflow when the signs differ
  assign sat_quo = res.quotient[N_BITS-1] ? -Q_MAX : Q_MAX;

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= res.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid) begin
      out_saturated <= res.overflow;
      // A clamped quotient has no meaningful remainder
      out_quotient  <= res.overflow ? sat_quo : res.quotient;
      out_remainder <= res.overflow ? '0 : res.remainder;
    end
  end

  ////////////////////
  // Overflow counter
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow_count <= '0;
    end else if (res.valid && res.overflow && (overflow_count != '1)) begin
      // Count sticks at all ones instead of wrapping
      overflow_count <= overflow_count + 1'b1;
    end
  end

endmodule

// ==== hw/fixed_div_pkg.sv ====
/*
  Shared definitions for the signed fixed-point divider
  - default operand width and number of fractional quotient bits
  - vector types for operands, results and the overflow counter
  - state encoding of the iterative division core
*/

package fixed_div_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Operand and result width in bits, sign included
  localparam int N_BITS_DEF = 16;

  // Quotient is scaled by 2^Q_BITS_DEF
  localparam int Q_BITS_DEF = 8;

  ////////////////////
  // Types
  ////////////////////

  // Two's-complement operand, quotient or remainder
  typedef logic signed [N_BITS_DEF-1:0] fix_t;

  // Number of results that were saturated, sticks at its maximum
  typedef logic [15:0] ovf_cnt_t;

  // Core is either waiting for a pair or iterating over quotient bits
  typedef enum logic {
    core_idle,
    core_run
  } core_state_e;

endpackage

// ==== hw/fixed_divider_top.sv ====
/*
  Signed fixed-point divider subsystem
  - operand queue with valid/ready input
  - iterative division core
  - saturating result stage with overflow counter
*/

`timescale 1ns/1ns

module fixed_divider_top import fixed_div_pkg::*; #(
  parameter int N_BITS     = N_BITS_DEF,
  parameter int Q_BITS     = Q_BITS_DEF,
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  fix_t     in_dividend,
  input  fix_t     in_divisor,
  output logic     out_valid,
  output fix_t     out_quotient,
  output fix_t     out_remainder,
  output logic     out_saturated,
  output ovf_cnt_t overflow_count
);

  // Queue to core, and core to result stage
  div_operand_if #(.N_BITS(N_BITS)) op_if ();
  div_result_if  #(.N_BITS(N_BITS)) res_if ();

  operand_fifo #(
    .N_BITS     (N_BITS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_valid    (in_valid),
    .wr_ready    (in_ready),
    .wr_dividend (in_dividend),
    .wr_divisor  (in_divisor),
    .rd          (op_if.src)
  );

  // One division in flight, the rest wait in the queue
  long_division_core #(
    .N_BITS (N_BITS),
    .Q_BITS (Q_BITS)
  ) u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .ing   (op_if.dst),
    .egr   (res_if.src)
  );

  div_result_stage #(
    .N_BITS (N_BITS)
  ) u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .res            (res_if.dst),
    .out_valid      (out_valid),
    .out_quotient   (out_quotient),
    .out_remainder  (out_remainder),
    .out_saturated  (out_saturated),
    .overflow_count (overflow_count)
  );

endmodule

// ==== hw/long_division_core.sv ====
/*
  Iterative sign-magnitude restoring divider
  - one quotient bit per clock, N_BITS+Q_BITS iterations per pair
  - quotient scaled by 2^Q_BITS, remainder of the scaled division
  - overflow flag for quotients that do not fit, division by zero included
*/

`timescale 1ns/1ns

module long_division_core import fixed_div_pkg::*; #(
  parameter int N_BITS = 16,
  parameter int Q_BITS = 8
) (
  input  logic          clk,
  input  logic          rst_n,
  div_operand_if.dst    ing,
  div_result_if.src     egr
);

  // Number of iterations and width of the scaled dividend
  localparam int W     = N_BITS + Q_BITS;
  localparam int DVS_W = N_BITS + W - 1;
  localparam int CNT_W = $clog2(W);

  core_state_e state_q;

  // Partial remainder, shifted divisor and quotient magnitude
  logic [W-1:0]     rem_q;
  logic [DVS_W-1:0] dvs_q;
  logic [W-1:0]     quo_q;
  logic [CNT_W-1:0] cnt_q;
  logic             sign_q;

  // Registered result presented on the egress interface
  logic                     res_valid_q;
  logic signed [N_BITS-1:0] res_quo_q;
  logic signed [N_BITS-1:0] res_rem_q;
  logic                     res_ovf_q;

  logic              accept;
  logic [N_BITS-1:0] dvd_mag;
  logic [N_BITS-1:0] dvs_mag;
  logic              fits;
  logic [W-1:0]      rem_next;
  logic [W-1:0]      quo_next;
  logic              ovf_next;

  assign ing.ready = (state_q == core_idle);
  assign accept    = ing.valid && ing.ready;

  // Magnitudes of the operands, the most negative value is not supported
  assign dvd_mag = ing.dividend[N_BITS-1] ? -ing.dividend : ing.dividend;
  assign dvs_mag = ing.divisor[N_BITS-1] ? -ing.divisor : ing.divisor;

  ////////////////////
  // One iteration
  ////////////////////

  // Compare-subtract against the current divisor position
  assign fits     = ({{(N_BITS-1){1'b0}}, rem_q} >= dvs_q);
  assign rem_next = fits ? rem_q - dvs_q[W-1:0] : rem_q;
  assign quo_next = {quo_q[W-2:0], fits};

  // Magnitude of 2^(N_BITS-1) or more cannot be shown as a signed result
  assign ovf_next = |quo_next[W-1:N_BITS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= core_idle;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= 1'b0;
      if (accept) begin
        state_q <= core_run;
        cnt_q   <= CNT_W'(W - 1);
      end else if (state_q == core_run) begin
        cnt_q <= cnt_q - 1'b1;
        // Last iteration edge, ready returns together with the result
        if (cnt_q == '0) begin
          state_q     <= core_idle;
          res_valid_q <= 1'b1;
        end
      end
    end
  end

  // Datapath registers carry no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      // Dividend sits above Q_BITS zero fraction bits
      rem_q  <= {dvd_mag, {Q_BITS{1'b0}}};
      // Divisor is left-aligned to the top of the scaled dividend
      dvs_q  <= {dvs_mag, {(W-1){1'b0}}};
      quo_q  <= '0;
      sign_q <= ing.dividend[N_BITS-1] ^ ing.divisor[N_BITS-1];
    end else if (state_q == core_run) begin
      rem_q <= rem_next;
      dvs_q <= dvs_q >> 1;
      quo_q <= quo_next;
      if (cnt_q == '0) begin
        res_ovf_q <= ovf_next;
        res_rem_q <= sign_q ? -rem_next[N_BITS-1:0] : rem_next[N_BITS-1:0];
        // On overflow only the sign matters, the top bit carries it
        if (ovf_next) begin
          res_quo_q <= {sign_q, {(N_BITS-1){~sign_q}}};
        end else begin
          res_quo_q <= sign_q ? -quo_next[N_BITS-1:0] : quo_next[N_BITS-1:0];
        end
      end
    end
  end

  assign egr.valid     = res_valid_q;
  assign egr.quotient  = res_quo_q;
  assign egr.remainder = res_rem_q;
  assign egr.overflow  = res_ovf_q;

endmodule

// ==== hw/operand_fifo.sv ====
/*
  First-word-fall-through queue of operand pairs
  - circular buffer with read and write pointers
  - occupancy count for the full and empty flags
  - head pair is shown on the operand interface while not empty
*/

`timescale 1ns/1ns

module operand_fifo import fixed_div_pkg::*; #(
  parameter int N_BITS     = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wr_valid,
  output logic          wr_ready,
  input  fix_t          wr_dividend,
  input  fix_t          wr_divisor,
  div_operand_if.src    rd
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Storage for the two halves of each pair
  logic signed [N_BITS-1:0] dvd_mem [FIFO_DEPTH];
  logic signed [N_BITS-1:0] dvs_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  // Producer stalls only when every slot is taken
  assign wr_ready = (count != CNT_W'(FIFO_DEPTH));
  assign push     = wr_valid && wr_ready;
  assign pop      = rd.valid && rd.ready;

  // The head entry falls through to the core without an extra cycle
  assign rd.valid    = (count != '0);
  assign rd.dividend = dvd_mem[rd_ptr];
  assign rd.divisor  = dvs_mem[rd_ptr];

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      dvd_mem[wr_ptr] <= wr_dividend;
      dvs_mem[wr_ptr] <= wr_divisor;
    end
  end

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap explicitly so that any depth works
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the occupancy unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== sim/fixed_divider_chk.sv ====
/*
  Concurrent assertions for the division core
  - result valid arrives a fixed number of edges after each accept
  - ready stays low while the core iterates
  - result valid is a single-cycle pulse
*/

`timescale 1ns/1ns

module fixed_divider_chk #(
  parameter int ITER = 24
) (
  input logic clk,
  input logic rst_n,
  input logic accept,
  input logic ready,
  input logic valid
);

  // Number of failed assertions, read by the testbench at the end
  int err_cnt = 0;

  // Valid is set on the last of ITER iteration edges and is sampled on the edge after it
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !valid [*ITER] ##1 valid)
    else begin
      err_cnt = err_cnt + 1;
      $error("core result not seen %0d edges after accept", ITER + 1);
    end

  // No new pair may enter while the iterations run
  a_busy : assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !ready [*ITER] ##1 ready)
    else begin
      err_cnt = err_cnt + 1;
      $error("core ready high during a division or not back afterwards");
    end

  a_pulse : assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
    else begin
      err_cnt = err_cnt + 1;
      $error("core result valid high for two cycles in a row");
    end

endmodule

// ==== sim/fixed_divider_scoreboard.sv ====
/*
  Result checker for the fixed-point divider testbench
  - queue of accepted operand pairs in arrival order
  - reference division with truncation toward zero and saturation
  - latency check for pairs that enter an empty subsystem
  - one line per checked result, pass and fail counts
*/

`timescale 1ns/1ns

module fixed_divider_scoreboard import fixed_div_pkg::*; #(
  parameter int N_BITS = 16,
  parameter int Q_BITS = 8
) (
  input logic     clk,
  input logic     rst_n,
  input logic     in_valid,
  input logic     in_ready,
  input fix_t     in_dividend,
  input fix_t     in_divisor,
  input logic     out_valid,
  input fix_t     out_quotient,
  input fix_t     out_remainder,
  input logic     out_saturated,
  input ovf_cnt_t overflow_count
);

  // out_valid rises N_BITS+Q_BITS+2 edges after accept and is first sampled one edge later
  localparam int FIRST_SEEN = N_BITS + Q_BITS + 3;

  ////////////////////
  // Model state
  ////////////////////

  fix_t     a_q[$];
  fix_t     b_q[$];
  int       stamp_q[$];
  bit       timed_q[$];

  int       cyc      = 0;
  int       pending  = 0;
  int       pass_cnt = 0;
  int       fail_cnt = 0;
  ovf_cnt_t ovf_model = '0;

  fix_t a;
  fix_t b;
  fix_t exp_q;
  fix_t exp_r;
  bit   exp_sat;
  bit   ok;
  bit   timed;
  int   stamp;

  // Scaled magnitude division with the sign applied afterwards
  task automatic divide_model(input fix_t dvd, input fix_t dvs,
                              output fix_t q, output fix_t r, output bit sat);
    longint mag_a;
    longint mag_b;
    longint mag_q;
    longint mag_r;
    longint limit;
    bit     neg;
    mag_a = (dvd < 0) ? -longint'(dvd) : longint'(dvd);
    mag_b = (dvs < 0) ? -longint'(dvs) : longint'(dvs);
    neg   = (dvd < 0) != (dvs < 0);
    limit = (longint'(1) << (N_BITS - 1)) - 1;
    mag_q = 0;
    mag_r = 0;
    sat   = (mag_b == 0);
    if (!sat) begin
      mag_q = (mag_a << Q_BITS) / mag_b;
      mag_r = (mag_a << Q_BITS) % mag_b;
      sat   = (mag_q > limit);
    end
    // A saturated result keeps the sign and drops the remainder
    if (sat) begin
      q = fix_t'(neg ? -limit : limit);
      r = '0;
    end else begin
      q = fix_t'(neg ? -mag_q : mag_q);
      r = fix_t'(neg ? -mag_r : mag_r);
    end
  endtask

  ////////////////////
  // Compare on every result
  ////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      if (out_valid) begin
        if (a_q.size() == 0) begin
          fail_cnt = fail_cnt + 1;
          $display("FAIL t=%0t: result appeared with no accepted pair waiting", $time);
        end else begin
          a     = a_q.pop_front();
          b     = b_q.pop_front();
          stamp = stamp_q.pop_front();
          timed = timed_q.pop_front();
          divide_model(a, b, exp_q, exp_r, exp_sat);
          if (exp_sat && (ovf_model != '1)) begin
            ovf_model = ovf_model + 1'b1;
          end
          ok = (out_quotient === exp_q) && (out_remainder === exp_r) &&
               (out_saturated === exp_sat) && (overflow_count === ovf_model);
          if (ok) begin
            pass_cnt = pass_cnt + 1;
            $display("PASS t=%0t a=%0d b=%0d q=%0d r=%0d sat=%0b", $time, a, b,
                     out_quotient, out_remainder, out_saturated);
          end else begin
            fail_cnt = fail_cnt + 1;
            // Each field shows the DUT value followed by the model value
            $display("FAIL t=%0t a=%0d b=%0d: q=%0d/%0d r=%0d/%0d sat=%0b/%0b cnt=%0d/%0d",
                     $time, a, b, out_quotient, exp_q, out_remainder, exp_r,
                     out_saturated, exp_sat, overflow_count, ovf_model);
          end
          if (timed && (cyc - stamp != FIRST_SEEN)) begin
            fail_cnt = fail_cnt + 1;
            $display("FAIL t=%0t a=%0d b=%0d: latency %0d cycles, expected %0d", $time, a, b,
                     cyc - stamp - 1, N_BITS + Q_BITS + 2);
          end
        end
      end
      // A pair entering with nothing outstanding has the fixed latency
      if (in_valid && in_ready) begin
        timed_q.push_back(a_q.size() == 0);
        a_q.push_back(in_dividend);
        b_q.push_back(in_divisor);
        stamp_q.push_back(cyc);
      end
      pending = a_q.size();
    end
  end

endmodule

// ==== sim/fixed_divider_tb.sv ====
/*
  Testbench top for the signed fixed-point divider
  - clock, reset and cycle-count timeout
  - random operand stimulus in five test phases
  - DUT instance, result checker and bound core assertions
  - final summary of pass and fail counts
*/

`timescale 1ns/1ns

module fixed_divider_tb import fixed_div_pkg::*; ();

  localparam int N_BITS     = N_BITS_DEF;
  localparam int Q_BITS     = Q_BITS_DEF;
  localparam int FIFO_DEPTH = 4;

  // Operations per phase, the first phase is a single division
  localparam int N_RANDOM       = 40;
  localparam int N_SAT          = 12;
  localparam int N_BURST        = 12;
  localparam int N_MIXED        = 40;
  localparam int NUM_OPS        = 1 + N_RANDOM + N_SAT + N_BURST + N_MIXED;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (N_BITS + Q_BITS + 4) + 200;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  logic     in_ready;
  fix_t     in_dividend;
  fix_t     in_divisor;
  logic     out_valid;
  fix_t     out_quotient;
  fix_t     out_remainder;
  logic     out_saturated;
  ovf_cnt_t overflow_count;

  int cycles  = 0;
  int tb_pass = 0;
  int tb_fail = 0;

  fixed_divider_top #(
    .N_BITS     (N_BITS),
    .Q_BITS     (Q_BITS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (.*);

  fixed_divider_scoreboard #(
    .N_BITS (N_BITS),
    .Q_BITS (Q_BITS)
  ) scb (.*);

  bind long_division_core fixed_divider_chk #(.ITER(N_BITS + Q_BITS)) u_chk (
    .clk    (clk),
    .rst_n  (rst_n),
    .accept (accept),
    .ready  (ing.ready),
    .valid  (egr.valid)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Timeout
  ////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run hung, divider still busy after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Random magnitude in lo..hi, negated on request, never the most negative value
  function automatic fix_t signed_operand(input int lo, input int hi, input bit neg);
    fix_t mag;
    mag = fix_t'($urandom_range(hi, lo));
    return neg ? -mag : mag;
  endfunction

  task automatic record_check(input bit ok, input string what);
    if (ok) begin
      tb_pass = tb_pass + 1;
    end else begin
      tb_fail = tb_fail + 1;
      $display("FAIL t=%0t: %s", $time, what);
    end
  endtask

  // Holds the pair from the falling edge until the queue has room
  task automatic send_pair(input fix_t dvd, input fix_t dvs, output bit was_stalled);
    @(negedge clk);
    in_valid    = 1'b1;
    in_dividend = dvd;
    in_divisor  = dvs;
    was_stalled = !in_ready;
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic idle_for(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // Returns once every accepted pair has produced its result
  task automatic wait_drained();
    idle_for(1);
    while (scb.pending != 0) begin
      @(negedge clk);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int   i;
    int   first_stall;
    int   pass_total;
    int   fail_total;
    bit   stalled;
    fix_t a;
    fix_t b;
    void'($urandom(84));
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_dividend = '0;
    in_divisor  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state, then one positive division into an idle subsystem
    record_check(!out_valid && in_ready, "out_valid high or in_ready low after reset");
    a = signed_operand(1000, 20000, 1'b0);
    b = signed_operand(300, 9000, 1'b0);
    send_pair(a, b, stalled);
    wait_drained();
    $display("test 1 reset and single division done");

    // Sign combinations cycle with the loop index
    for (i = 0; i < N_RANDOM; i++) begin
      a = signed_operand(0, 32767, i[0]);
      b = signed_operand(256, 32767, i[1]);
      send_pair(a, b, stalled);
    end
    wait_drained();
    $display("test 2 random signed operands done");

    // Quotients of at least 128 do not fit, the first three divide by zero
    for (i = 0; i < N_SAT; i++) begin
      a = signed_operand(4096, 32767, $urandom_range(1, 0));
      b = (i < 3) ? fix_t'(0) : signed_operand(1, 15, $urandom_range(1, 0));
      send_pair(a, b, stalled);
    end
    wait_drained();
    $display("test 3 saturation done");

    // One pair goes straight to the core, the next FIFO_DEPTH fill the queue
    first_stall = -1;
    for (i = 0; i < N_BURST; i++) begin
      a = signed_operand(0, 32767, $urandom_range(1, 0));
      b = signed_operand(1, 32767, $urandom_range(1, 0));
      send_pair(a, b, stalled);
      if (stalled && (first_stall < 0)) begin
        first_stall = i;
      end
    end
    record_check(first_stall == FIFO_DEPTH + 1, "in_ready did not drop after a full queue");
    wait_drained();
    $display("test 4 burst into full queue done");

    for (i = 0; i < N_MIXED; i++) begin
      if ($urandom_range(2, 0) == 0) begin
        idle_for($urandom_range(8, 1));
      end
      a = signed_operand(0, 32767, $urandom_range(1, 0));
      b = signed_operand(0, 32767, $urandom_range(1, 0));
      send_pair(a, b, stalled);
    end
    wait_drained();
    $display("test 5 gaps and bursts done");

    // A stray extra result would show up in this window
    idle_for(N_BITS + Q_BITS + 4);
    pass_total = scb.pass_cnt + tb_pass;
    fail_total = scb.fail_cnt + tb_fail + uut.u_core.u_chk.err_cnt;
    $display("passed %0d failed %0d", pass_total, fail_total);
    if (fail_total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
